// ==== files.f ====
+incdir+source
source/snd_pkg.sv
source/z80_mem_map.sv
source/qsound_regs.sv
source/z80_int_timer.sv
source/dsp_audio_latch.sv
source/snd_glue_top.sv
verification/tb_clock_gen.sv
verification/snd_glue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module snd_glue_tb -f files.f -o snd_glue_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/snd_glue_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
fi
exit 1

// ==== verification/snd_glue_tb.sv ====
`timescale 1ns/100ps
`include "snd_params.svh"

module snd_glue_tb;
    import snd_pkg::*;

    localparam int int_period = 50;
    localparam int cen_div    = 6;      // 48 MHz / 8 MHz

    typedef enum {op_rd, op_wr, op_rst, op_dsp, op_int, op_audio} op_e;

    logic        clk48;
    logic        rst;
    logic        cen8 = 1'b0;
    z80_bus_t    z80_bus;
    logic [ 7:0] z80_din;
    logic        wait_n;
    logic        int_n;
    logic [18:0] rom_addr;
    logic        rom_cs;
    logic [ 7:0] rom_data = 8'h00;
    logic        rom_ok = 1'b0;
    dsp_word_t   dsp_word;
    logic        dsp_valid;
    logic        dsp_ready = 1'b0;
    logic        dsp_rst;
    logic        dsp_sadd;
    logic        dsp_psel;
    dsp_word_t   dsp_serout;
    stereo_t     audio;
    logic        audio_valid;

    // stimulus table
    string       row_name[$];
    op_e         row_op[$];
    logic [15:0] row_addr[$];
    logic [ 7:0] row_data[$];
    logic [31:0] row_exp[$];

    dsp_word_t   dsp_rx[$];             // words taken by the DSP side
    int          fall_ticks[$];         // cen8 tick count at each int_n fall
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;
    int          ticks = 0;
    int          div = 0;
    logic        int_n_last = 1'b1;
    logic        ready_en = 1'b0;
    logic        hold_check = 1'b0;
    dsp_word_t   held_word = '0;

    tb_clock_gen u_clock_gen (
        .clk48 ( clk48 ),
        .rst   ( rst   )
    );

    snd_glue_top #(
        .int_period ( int_period )
    ) u_snd_glue_top (
        .clk48       ( clk48       ),
        .rst         ( rst         ),
        .cen8        ( cen8        ),
        .z80_bus     ( z80_bus     ),
        .z80_din     ( z80_din     ),
        .wait_n      ( wait_n      ),
        .int_n       ( int_n       ),
        .rom_addr    ( rom_addr    ),
        .rom_cs      ( rom_cs      ),
        .rom_data    ( rom_data    ),
        .rom_ok      ( rom_ok      ),
        .dsp_word    ( dsp_word    ),
        .dsp_valid   ( dsp_valid   ),
        .dsp_ready   ( dsp_ready   ),
        .dsp_rst     ( dsp_rst     ),
        .dsp_sadd    ( dsp_sadd    ),
        .dsp_psel    ( dsp_psel    ),
        .dsp_serout  ( dsp_serout  ),
        .audio       ( audio       ),
        .audio_valid ( audio_valid )
    );

    function automatic logic [7:0] rom_byte(input logic [18:0] a);
        return a[7:0] ^ 8'h5a;
    endfunction

    function automatic logic [18:0] bank_rom_addr(input logic [3:0] bank, input logic [13:0] ofs);
        return 19'(`SND_BANK_BASE) + 19'(bank) * 19'h04000 + 19'(ofs);
    endfunction

    function automatic logic [7:0] status_byte(input logic pending, input logic [3:0] bank);
        return {~pending, 3'b111, bank};
    endfunction

    task automatic add_row(input string name, input op_e op, input logic [15:0] addr,
                           input logic [7:0] data, input logic [31:0] exp);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_exp.push_back(exp);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk48);
        z80_bus.addr = addr;
        z80_bus.dout = data;
        z80_bus.mreq = 1'b1;
        z80_bus.wr   = 1'b1;
        repeat (2) @(negedge clk48);
        z80_bus.mreq = 1'b0;
        z80_bus.wr   = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data,
                            output logic [18:0] rom_a, output logic stalled);
        @(negedge clk48);
        z80_bus.addr = addr;
        z80_bus.mreq = 1'b1;
        z80_bus.rd   = 1'b1;
        @(negedge clk48);
        stalled = !wait_n;      // ROM selected, answer not back yet
        @(negedge clk48);
        while (!wait_n)
            @(negedge clk48);   // ROM not ready yet
        data  = z80_din;
        rom_a = rom_addr;
        z80_bus.mreq = 1'b0;
        z80_bus.rd   = 1'b0;
    endtask

    task automatic int_ack;
        @(negedge clk48);
        z80_bus.m1   = 1'b1;
        z80_bus.iorq = 1'b1;
        while (!int_n)
            @(negedge clk48);   // held until a cen8 tick sees it
        z80_bus.m1   = 1'b0;
        z80_bus.iorq = 1'b0;
    endtask

    // right word first while psel is high, then left, then psel rises
    task automatic audio_frame(input logic [15:0] left, input logic [15:0] right,
                               output int pulses, output stereo_t got);
        @(negedge clk48);
        dsp_sadd   = 1'b1;
        dsp_serout = right;
        @(negedge clk48);
        dsp_sadd   = 1'b0;
        @(negedge clk48);
        dsp_psel   = 1'b0;
        dsp_sadd   = 1'b1;
        dsp_serout = left;
        @(negedge clk48);
        dsp_sadd   = 1'b0;
        @(negedge clk48);
        dsp_psel   = 1'b1;
        pulses = 0;
        got    = '0;
        repeat (4) begin
            @(negedge clk48);
            if (audio_valid) begin
                pulses++;
                got = audio;
            end
        end
    endtask

    // ROM read rows carry the expected ROM address above the data byte
    task automatic build_table;
        add_row("rom fixed read", op_rd, 16'h1234, 8'h00,
                {5'd0, 19'h01234, rom_byte(19'h01234)});
        add_row("bank write", op_wr, {`SND_REGION_QSND, 12'h003}, 8'h83, 32'd0);
        add_row("rom bank read", op_rd, 16'h8010, 8'h00,
                {5'd0, bank_rom_addr(4'd3, 14'h0010),
                 rom_byte(bank_rom_addr(4'd3, 14'h0010))});
        add_row("dsp reset released", op_rst, 16'h0000, 8'h00, 32'd0);
        add_row("ram lo write", op_wr, {`SND_REGION_RAM_LO, 12'h005}, 8'ha5, 32'd0);
        add_row("ram hi write", op_wr, {`SND_REGION_RAM_HI, 12'h005}, 8'h3c, 32'd0);
        add_row("ram lo read", op_rd, {`SND_REGION_RAM_LO, 12'h005}, 8'h00, 32'h0000_00a5);
        add_row("ram hi read", op_rd, {`SND_REGION_RAM_HI, 12'h005}, 8'h00, 32'h0000_003c);
        add_row("cmd msb write", op_wr, {`SND_REGION_QSND, 12'h000}, 8'h12, 32'd0);
        add_row("cmd lsb write", op_wr, {`SND_REGION_QSND, 12'h001}, 8'h34, 32'd0);
        add_row("cmd addr write", op_wr, {`SND_REGION_QSND, 12'h002}, 8'h56, 32'd0);
        add_row("status pending", op_rd, {`SND_REGION_QSND, 12'h007}, 8'h00,
                {24'd0, status_byte(1'b1, 4'd3)});
        add_row("dsp data word", op_dsp, 16'h0000, 8'h00, 32'h0000_1234);
        add_row("dsp addr word", op_dsp, 16'h0000, 8'h00, 32'h0000_0056);
        add_row("status taken", op_rd, {`SND_REGION_QSND, 12'h007}, 8'h00,
                {24'd0, status_byte(1'b0, 4'd3)});
        add_row("first interrupt", op_int, 16'h0000, 8'h00, 32'(int_period));
        add_row("second interrupt", op_int, 16'h0000, 8'h00, 32'(2 * int_period));
        add_row("audio pair", op_audio, 16'h0000, 8'h00, {16'h1357, 16'hfeca});
    endtask

    // ROM answers one cycle after select
    always @(posedge clk48 or posedge rst) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_data <= 8'h00;
        end else begin
            rom_ok   <= rom_cs;
            rom_data <= rom_byte(rom_addr);
        end
    end

    // cen8 every 6th cycle, int_n falls logged against the tick count
    always @(negedge clk48) begin
        if (int_n_last && !int_n)
            fall_ticks.push_back(ticks);
        int_n_last = int_n;
        if (rst) begin
            div  = 0;
            cen8 = 1'b0;
        end else begin
            cen8 = (div == cen_div - 1);
            div  = (div == cen_div - 1) ? 0 : div + 1;
            if (cen8)
                ticks++;
        end
    end

    // random back-pressure, a stalled word must hold
    initial begin
        void'($urandom(32'h2c2));
        forever begin
            @(negedge clk48);
            if (hold_check) begin
                if (!dsp_valid) begin
                    $display("dsp_valid dropped while a word was stalled");
                    errors++;
                end else if (dsp_word !== held_word) begin
                    report_mismatch("dsp hold", {16'd0, held_word}, {16'd0, dsp_word});
                end
            end
            dsp_ready = ready_en && ($urandom % 2 == 1);
            if (dsp_valid && dsp_ready)
                dsp_rx.push_back(dsp_word);     // taken at the next rising edge
            hold_check = dsp_valid && !dsp_ready;
            held_word  = dsp_word;
        end
    end

    always @(posedge clk48) begin
        if (!rst)
            cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [ 7:0] rd_byte;
        logic [18:0] rd_rom_addr;
        logic        stalled;
        logic        is_rom;
        stereo_t     got_pair;
        int          pulses;
        int          errs_before;
        int          failed_rows;
        int          dsp_seen;
        int          int_seen;

        z80_bus     = '0;
        dsp_sadd    = 1'b0;
        dsp_psel    = 1'b1;
        dsp_serout  = '0;
        failed_rows = 0;
        dsp_seen    = 0;
        int_seen    = 0;
        build_table();
        limit = row_name.size() * 10 + 4 * int_period * cen_div;

        @(negedge rst);
        @(negedge clk48);

        for (int i = 0; i < row_name.size(); i++) begin
            errs_before = errors;
            case (row_op[i])
                op_wr: bus_write(row_addr[i], row_data[i]);
                op_rd: begin
                    bus_read(row_addr[i], rd_byte, rd_rom_addr, stalled);
                    is_rom = row_addr[i][15:14] != 2'b11;
                    if (rd_byte !== row_exp[i][7:0])
                        report_mismatch(row_name[i], {24'd0, row_exp[i][7:0]},
                                        {24'd0, rd_byte});
                    if (stalled !== is_rom)
                        report_mismatch({row_name[i], " wait"}, {31'd0, is_rom},
                                        {31'd0, stalled});
                    if (is_rom && rd_rom_addr !== row_exp[i][26:8])
                        report_mismatch({row_name[i], " address"}, {13'd0, row_exp[i][26:8]},
                                        {13'd0, rd_rom_addr});
                end
                op_rst: begin
                    if (dsp_rst !== row_exp[i][0])
                        report_mismatch(row_name[i], row_exp[i], {31'd0, dsp_rst});
                end
                op_dsp: begin
                    ready_en = 1'b1;
                    while (dsp_rx.size() <= dsp_seen)
                        @(negedge clk48);
                    if (dsp_rx[dsp_seen] !== row_exp[i][15:0])
                        report_mismatch(row_name[i], row_exp[i], {16'd0, dsp_rx[dsp_seen]});
                    dsp_seen++;
                end
                op_int: begin
                    while (fall_ticks.size() <= int_seen)
                        @(negedge clk48);
                    if (fall_ticks[int_seen] != row_exp[i])
                        report_mismatch(row_name[i], row_exp[i], 32'(fall_ticks[int_seen]));
                    int_seen++;
                    int_ack();
                end
                op_audio: begin
                    audio_frame(row_exp[i][31:16], row_exp[i][15:0], pulses, got_pair);
                    if (pulses != 1)
                        report_mismatch({row_name[i], " pulses"}, 32'd1, 32'(pulses));
                    if (got_pair !== row_exp[i])
                        report_mismatch(row_name[i], row_exp[i], got_pair);
                end
            endcase
            if (errors != errs_before)
                failed_rows++;
            $display("%-20s %s", row_name[i], (errors == errs_before) ? "ok" : "FAILED");
        end

        // nothing extra may reach the DSP after the pair
        if (dsp_rx.size() != dsp_seen)
            report_mismatch("dsp word count", 32'(dsp_seen), 32'(dsp_rx.size()));

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 row_name.size(), failed_rows, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk48,
    output logic rst
);
    localparam int half_period = 10;    // 20 ns clock
    localparam int rst_cycles  = 8;

    initial begin
        clk48 = 1'b0;
        forever #half_period clk48 = ~clk48;
    end

    // release on a falling edge, well away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk48);
        @(negedge clk48);
        rst = 1'b0;
    end

endmodule

// ==== source/snd_glue_top.sv ====
`timescale 1ns/100ps
`include "snd_params.svh"

module snd_glue_top #(
    parameter int int_period = `SND_INT_PERIOD
) (
    input  logic               clk48,
    input  logic               rst,
    input  logic               cen8,
    // Z80 side
    input  snd_pkg::z80_bus_t  z80_bus,
    output logic [ 7:0]        z80_din,
    output logic               wait_n,
    output logic               int_n,
    // program ROM
    output logic [18:0]        rom_addr,
    output logic               rom_cs,
    input  logic [ 7:0]        rom_data,
    input  logic               rom_ok,
    // DSP parallel input
    output snd_pkg::dsp_word_t dsp_word,
    output logic               dsp_valid,
    input  logic               dsp_ready,
    output logic               dsp_rst,
    // DSP serial output
    input  logic               dsp_sadd,
    input  logic               dsp_psel,
    input  snd_pkg::dsp_word_t dsp_serout,
    output snd_pkg::stereo_t   audio,
    output logic               audio_valid
);
    import snd_pkg::*;

    logic [3:0] bank;
    logic [7:0] status;
    reg_write_t reg_wr;

    z80_mem_map u_mem_map (
        .clk48     ( clk48    ),
        .rst       ( rst      ),
        .z80_bus   ( z80_bus  ),
        .bank      ( bank     ),
        .status    ( status   ),
        .rom_data  ( rom_data ),
        .rom_ok    ( rom_ok   ),
        .rom_addr  ( rom_addr ),
        .rom_cs    ( rom_cs   ),
        .wait_n    ( wait_n   ),
        .reg_wr    ( reg_wr   ),
        .status_rd (          ),    // read strobe, only used inside the map
        .z80_din   ( z80_din  )
    );

    qsound_regs u_regs (
        .clk48     ( clk48     ),
        .rst       ( rst       ),
        .reg_wr    ( reg_wr    ),
        .bank      ( bank      ),
        .dsp_rst   ( dsp_rst   ),
        .status    ( status    ),
        .dsp_word  ( dsp_word  ),
        .dsp_valid ( dsp_valid ),
        .dsp_ready ( dsp_ready )
    );

    z80_int_timer #(
        .period ( int_period )
    ) u_int_timer (
        .clk48   ( clk48   ),
        .rst     ( rst     ),
        .cen8    ( cen8    ),
        .z80_bus ( z80_bus ),
        .int_n   ( int_n   )
    );

    dsp_audio_latch u_audio (
        .clk48       ( clk48       ),
        .rst         ( rst         ),
        .dsp_sadd    ( dsp_sadd    ),
        .dsp_psel    ( dsp_psel    ),
        .dsp_serout  ( dsp_serout  ),
        .audio       ( audio       ),
        .audio_valid ( audio_valid )
    );

endmodule

// ==== source/dsp_audio_latch.sv ====
`timescale 1ns/100ps

module dsp_audio_latch (
    input  logic               clk48,
    input  logic               rst,
    input  logic               dsp_sadd,
    input  logic               dsp_psel,
    input  snd_pkg::dsp_word_t dsp_serout,
    output snd_pkg::stereo_t   audio,
    output logic               audio_valid
);
    import snd_pkg::*;

    logic    last_sadd;
    logic    last_psel;
    stereo_t pair;          // channels as they come in

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            last_sadd   <= 1'b0;
            last_psel   <= 1'b1;    // no false edge if psel is high out of reset
            audio_valid <= 1'b0;
        end else begin
            last_sadd   <= dsp_sadd;
            last_psel   <= dsp_psel;
            audio_valid <= dsp_psel & ~last_psel;
        end
    end

    // serial interface bypassed, serout is taken as a parallel word
    always_ff @(posedge clk48) begin
        if (last_sadd && !dsp_sadd) begin
            if (dsp_psel)
                pair.right <= dsp_serout;
            else
                pair.left  <= dsp_serout;
        end
        if (dsp_psel && !last_psel)
            audio <= pair;
    end

endmodule

// ==== source/z80_int_timer.sv ====
`timescale 1ns/100ps
`include "snd_params.svh"

module z80_int_timer #(
    parameter int period = `SND_INT_PERIOD
) (
    input  logic              clk48,
    input  logic              rst,
    input  logic              cen8,
    input  snd_pkg::z80_bus_t z80_bus,
    output logic              int_n
);
    import snd_pkg::*;

    localparam int cnt_w = $clog2(period);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(period - 1);

    logic [cnt_w-1:0] cnt;
    logic             wrap;
    logic             ack;

    assign wrap = cnt == cnt_last;
    assign ack  = z80_bus.m1 & z80_bus.iorq;  // interrupt acknowledge cycle

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= wrap ? '0 : cnt + cnt_w'(1);
            if (ack)
                int_n <= 1'b1;
            else if (wrap)
                int_n <= 1'b0;  // stays low until acknowledged
        end
    end

endmodule

// ==== source/qsound_regs.sv ====
`timescale 1ns/100ps

module qsound_regs (
    input  logic                clk48,
    input  logic                rst,
    input  snd_pkg::reg_write_t reg_wr,
    output logic [3:0]          bank,
    output logic                dsp_rst,
    output logic [7:0]          status,
    output snd_pkg::dsp_word_t  dsp_word,
    output logic                dsp_valid,
    input  logic                dsp_ready
);
    import snd_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_msb_word,    // data word offered
        st_addr_word    // address word offered
    } xfer_state_e;

    xfer_state_e state;
    logic [7:0]  cmd_msb;
    logic [7:0]  cmd_lsb;
    logic [7:0]  cmd_addr;
    logic        irq_pending;
    logic        addr_wr;
    logic        take;

    assign addr_wr = reg_wr.valid && reg_wr.ofs == reg_addr;
    assign take    = dsp_valid & dsp_ready;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            bank    <= 4'd0;
            dsp_rst <= 1'b1;
        end else if (reg_wr.valid && reg_wr.ofs == reg_bank) begin
            bank    <= reg_wr.data[3:0];
            dsp_rst <= ~reg_wr.data[7];     // bit 7 lets the DSP run
        end
    end

    // the address byte is written last and starts the transfer
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else if (addr_wr) begin
            state <= st_msb_word;   // restarts a pair in flight too
        end else if (take) begin
            state <= (state == st_msb_word) ? st_addr_word : st_idle;
        end
    end

    always_ff @(posedge clk48) begin
        if (reg_wr.valid) begin
            case (reg_wr.ofs)
                reg_data_msb: cmd_msb  <= reg_wr.data;
                reg_data_lsb: cmd_lsb  <= reg_wr.data;
                reg_addr:     cmd_addr <= reg_wr.data;
                default: ;
            endcase
        end
        // word is a snapshot so later Z80 writes cannot disturb it
        if (addr_wr)
            dsp_word <= {cmd_msb, cmd_lsb};
        else if (take && state == st_msb_word)
            dsp_word <= {8'h00, cmd_addr};
    end

    assign irq_pending = state != st_idle;
    assign dsp_valid   = irq_pending;
    assign status      = {~irq_pending, 3'b111, bank};

endmodule

// ==== source/z80_mem_map.sv ====
`timescale 1ns/100ps
`include "snd_params.svh"

module z80_mem_map (
    input  logic              clk48,
    input  logic              rst,
    input  snd_pkg::z80_bus_t z80_bus,
    input  logic [ 3:0]       bank,
    input  logic [ 7:0]       status,
    input  logic [ 7:0]       rom_data,
    input  logic              rom_ok,
    output logic [18:0]       rom_addr,
    output logic              rom_cs,
    output logic              wait_n,
    output snd_pkg::reg_write_t reg_wr,
    output logic              status_rd,
    output logic [ 7:0]       z80_din
);
    import snd_pkg::*;

    localparam int ram_size = 2 ** `SND_RAM_AW;

    logic        access;        // memory cycle on the bus
    logic        access_q;
    logic        first;         // first clock of a cycle
    mem_region_e region_d;
    mem_region_e region;        // registered decode
    qsnd_reg_e   ofs;
    logic        ram_we;
    logic [ 7:0] ram [0:ram_size-1];
    logic [ 7:0] ram_q;

    function automatic mem_region_e decode_region(input logic [15:0] a);
        mem_region_e r;
        if (!a[15]) begin
            r = region_rom_fixed;
        end else if (!a[14]) begin
            r = region_rom_bank;
        end else begin
            case (a[15:12])
                `SND_REGION_RAM_LO, `SND_REGION_RAM_HI: r = region_ram;
                `SND_REGION_QSND: begin
                    // offset 7 is the status byte, the rest are latches
                    r = (qsnd_reg_e'(a[2:0]) == reg_status) ? region_status
                                                            : region_qsnd_reg;
                end
                default: r = region_none;
            endcase
        end
        return r;
    endfunction

    assign access   = z80_bus.mreq & (z80_bus.rd | z80_bus.wr);
    assign first    = access & ~access_q;
    assign region_d = access ? decode_region(z80_bus.addr) : region_none;
    assign ofs      = qsnd_reg_e'(z80_bus.addr[2:0]);
    assign ram_we   = first & z80_bus.wr & (region_d == region_ram);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            access_q <= 1'b0;
            region   <= region_none;
            rom_cs   <= 1'b0;
            reg_wr   <= '0;
        end else begin
            access_q     <= access;
            region       <= region_d;
            rom_cs       <= region_d == region_rom_fixed || region_d == region_rom_bank;
            // one pulse per write, offsets above bank are ignored
            reg_wr.valid <= first && z80_bus.wr && region_d == region_qsnd_reg
                            && z80_bus.addr[2:0] <= reg_bank;
            reg_wr.ofs   <= ofs;
            reg_wr.data  <= z80_bus.dout;
        end
    end

    always_ff @(posedge clk48) begin
        if (access) begin
            if (z80_bus.addr[15])
                rom_addr <= `SND_BANK_BASE + {1'b0, bank, z80_bus.addr[13:0]};
            else
                rom_addr <= {4'd0, z80_bus.addr[14:0]};
        end
    end

    // C000 and F000 land 4 kB apart in the 8 kB RAM
    always_ff @(posedge clk48) begin
        if (ram_we)
            ram[z80_bus.addr[`SND_RAM_AW-1:0]] <= z80_bus.dout;
        ram_q <= ram[z80_bus.addr[`SND_RAM_AW-1:0]];
    end

    assign status_rd = region == region_status;
    assign wait_n    = ~rom_cs | rom_ok;    // hold the CPU until SDRAM answers

    always_comb begin
        if (rom_cs)
            z80_din = rom_data;
        else if (region == region_ram)
            z80_din = ram_q;
        else if (status_rd)
            z80_din = status;
        else
            z80_din = 8'hff;    // open bus
    end

endmodule

// ==== source/snd_pkg.sv ====
`include "snd_params.svh"

package snd_pkg;

    // Z80 bus seen from the glue, strobes active high
    typedef struct packed {
        logic [15:0] addr;
        logic [ 7:0] dout;  // byte written by the CPU
        logic        mreq;
        logic        rd;
        logic        wr;
        logic        m1;
        logic        iorq;
    } z80_bus_t;

    typedef enum logic [2:0] {
        region_none,
        region_rom_fixed,   // 0000-7FFF
        region_rom_bank,    // 8000-BFFF
        region_ram,         // C000 and F000 pages
        region_qsnd_reg,    // D000 writes
        region_status       // D007 read
    } mem_region_e;

    typedef enum logic [`SND_REG_OFS_W-1:0] {
        reg_data_msb = `SND_REG_DATA_MSB,
        reg_data_lsb = `SND_REG_DATA_LSB,
        reg_addr     = `SND_REG_ADDR,
        reg_bank     = `SND_REG_BANK,
        reg_status   = `SND_REG_STATUS
    } qsnd_reg_e;

    typedef struct packed {
        logic       valid;
        qsnd_reg_e  ofs;
        logic [7:0] data;
    } reg_write_t;

    typedef logic [15:0] dsp_word_t;    // DSP16 parallel bus word

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } stereo_t;

endpackage

// ==== source/snd_params.svh ====
`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// interrupt period in cen8 ticks, 8 MHz / 32000 = 250 Hz
`define SND_INT_PERIOD 32000

// work RAM, 8 kB
`define SND_RAM_AW 13

// byte offset of bank 0 inside the 512 kB program ROM
`define SND_BANK_BASE 19'h08000

// address nibbles A[15:12] of the upper memory map
`define SND_REGION_RAM_LO 4'hc
`define SND_REGION_RAM_HI 4'hf
`define SND_REGION_QSND   4'hd

// QSound register page, offsets in A[2:0]
`define SND_REG_OFS_W    3
`define SND_REG_DATA_MSB 3'd0
`define SND_REG_DATA_LSB 3'd1
`define SND_REG_ADDR     3'd2
`define SND_REG_BANK     3'd3
`define SND_REG_STATUS   3'd7

`endif
